// ==== rtl/dma_pkg.sv ====
package dma_pkg;

    // bus widths
    localparam int ADDR_BITS = 32;
    localparam int DATA_BITS = 32;
    // len field holds beats minus one
    localparam int LEN_BITS = 8;

    localparam int MAX_BURST = 16;
    localparam int BURST_BYTES = MAX_BURST * 4;

    localparam int MEM_WORDS = 1024;
    localparam int MEM_ADDR_BITS = $clog2(MEM_WORDS);

    // shared by ar and aw
    typedef struct packed {
        logic                 valid;
        logic [ADDR_BITS-1:0] addr;
        logic [LEN_BITS-1:0]  len;
    } addr_chan_t;

    typedef struct packed {
        logic                 valid;
        logic [DATA_BITS-1:0] data;
        logic                 last;
    } rdata_chan_t;

    typedef struct packed {
        logic                 valid;
        logic [DATA_BITS-1:0] data;
        logic                 last;
    } wdata_chan_t;

    // every response is okay, so only valid travels
    typedef struct packed {
        logic valid;
    } bresp_chan_t;

    typedef struct packed {
        addr_chan_t  ar;
        addr_chan_t  aw;
        wdata_chan_t w;
        logic        rready;
        logic        bready;
    } m2s_t;

    typedef struct packed {
        logic        arready;
        logic        awready;
        logic        wready;
        rdata_chan_t r;
        bresp_chan_t b;
    } s2m_t;

    typedef enum logic [2:0] {
        IDLE, CHECK, AR_CH, AW_CH, BUSY, B_CH, FIN
    } dma_state_e;

    typedef enum logic [1:0] {
        H_IDLE, H_ADDR, H_DATA, H_RESP
    } host_state_e;

    typedef enum logic [1:0] {
        NONE, DMA, HOST
    } arb_owner_e;

endpackage

// ==== rtl/dma_fifo.sv ====
`timescale 1ns/100ps

module dma_fifo #(
    parameter int DEPTH = 2
) (
    input  logic                          clk,
    input  logic                          rst,
    input  logic                          wen_i,
    input  logic                          ren_i,
    input  logic [dma_pkg::DATA_BITS-1:0] data_i,
    output logic [dma_pkg::DATA_BITS-1:0] data_o,
    output logic                          empty_o,
    output logic                          full_o
);

    logic [dma_pkg::DATA_BITS-1:0] mem [DEPTH];
    logic [$clog2(DEPTH)-1:0]      wr_ptr_r;
    logic [$clog2(DEPTH)-1:0]      rd_ptr_r;
    logic [$clog2(DEPTH):0]        count_r;
    logic                          do_write;
    logic                          do_read;

    assign empty_o  = (count_r == '0);
    assign full_o   = (count_r == ($clog2(DEPTH)+1)'(DEPTH));
    // head word shows before it is popped
    assign data_o   = mem[rd_ptr_r];
    assign do_write = wen_i && !full_o;
    assign do_read  = ren_i && !empty_o;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            wr_ptr_r <= '0;
            rd_ptr_r <= '0;
            count_r  <= '0;
        end else begin
            if (do_write)
                wr_ptr_r <= (wr_ptr_r == ($clog2(DEPTH))'(DEPTH - 1)) ? '0 : wr_ptr_r + 1'b1;
            if (do_read)
                rd_ptr_r <= (rd_ptr_r == ($clog2(DEPTH))'(DEPTH - 1)) ? '0 : rd_ptr_r + 1'b1;
            if (do_write && !do_read)
                count_r <= count_r + 1'b1;
            else if (do_read && !do_write)
                count_r <= count_r - 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (do_write)
            mem[wr_ptr_r] <= data_i;
    end

endmodule

// ==== rtl/dma_master.sv ====
`timescale 1ns/100ps

module dma_master (
    input  logic                          clk,
    input  logic                          rst,
    input  logic                          dma_start_i,
    input  logic [dma_pkg::ADDR_BITS-1:0] src_addr_i,
    input  logic [dma_pkg::ADDR_BITS-1:0] dst_addr_i,
    input  logic [dma_pkg::DATA_BITS-1:0] qty_i,
    input  dma_pkg::s2m_t                 bus_i,
    output dma_pkg::m2s_t                 bus_o,
    output logic                          dma_fin_o
);

    dma_pkg::dma_state_e state_r;
    dma_pkg::dma_state_e state_nx;

    logic start;
    logic arhs;
    logic awhs;
    logic rhs;
    logic whs;
    logic bhs;
    logic wrfin;

    logic [dma_pkg::DATA_BITS-1:0] rem_qty_r;
    logic [dma_pkg::LEN_BITS-1:0]  burst_len_r;
    logic [dma_pkg::LEN_BITS-1:0]  next_len;
    logic [dma_pkg::LEN_BITS-1:0]  wcnt_r;
    logic [dma_pkg::ADDR_BITS-1:0] src_addr_r;
    logic [dma_pkg::ADDR_BITS-1:0] dst_addr_r;

    logic [dma_pkg::DATA_BITS-1:0] fifo_dout;
    logic                          fifo_empty;
    logic                          fifo_full;

    // strobes while busy are dropped
    assign start = dma_start_i && (state_r == dma_pkg::IDLE);

    assign arhs  = bus_o.ar.valid && bus_i.arready;
    assign awhs  = bus_o.aw.valid && bus_i.awready;
    assign rhs   = bus_i.r.valid && bus_o.rready;
    assign whs   = bus_o.w.valid && bus_i.wready;
    assign bhs   = bus_i.b.valid && bus_o.bready;
    assign wrfin = whs && bus_o.w.last;

    // next burst length, capped at MAX_BURST beats
    assign next_len = (rem_qty_r > (dma_pkg::DATA_BITS)'(dma_pkg::MAX_BURST))
                    ? (dma_pkg::LEN_BITS)'(dma_pkg::MAX_BURST - 1)
                    : (dma_pkg::LEN_BITS)'(rem_qty_r - 1'b1);

    assign dma_fin_o = (state_r == dma_pkg::FIN);

    always_comb begin
        state_nx = state_r;
        case (state_r)
            dma_pkg::IDLE:  if (start) state_nx = dma_pkg::CHECK;
            dma_pkg::CHECK: state_nx = (rem_qty_r != '0) ? dma_pkg::AR_CH : dma_pkg::FIN;
            dma_pkg::AR_CH: if (arhs) state_nx = dma_pkg::AW_CH;
            dma_pkg::AW_CH: if (awhs) state_nx = dma_pkg::BUSY;
            dma_pkg::BUSY:  if (wrfin) state_nx = dma_pkg::B_CH;
            dma_pkg::B_CH: begin
                if (bhs)
                    state_nx = (rem_qty_r == '0) ? dma_pkg::FIN : dma_pkg::AR_CH;
            end
            default: state_nx = dma_pkg::IDLE;
        endcase
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state_r     <= dma_pkg::IDLE;
            rem_qty_r   <= '0;
            burst_len_r <= '0;
            wcnt_r      <= '0;
        end else begin
            state_r <= state_nx;
            if (start)
                rem_qty_r <= qty_i;
            else if (wrfin)
                rem_qty_r <= rem_qty_r - burst_len_r - 1'b1;
            // rem_qty_r already counts the finished burst here
            if (state_r == dma_pkg::CHECK || (state_r == dma_pkg::B_CH && bhs))
                burst_len_r <= next_len;
            if (wrfin)
                wcnt_r <= '0;
            else if (whs)
                wcnt_r <= wcnt_r + 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (start) begin
            src_addr_r <= src_addr_i;
            dst_addr_r <= dst_addr_i;
        end else if (state_r == dma_pkg::B_CH && bhs) begin
            src_addr_r <= src_addr_r + (dma_pkg::ADDR_BITS)'(dma_pkg::BURST_BYTES);
            dst_addr_r <= dst_addr_r + (dma_pkg::ADDR_BITS)'(dma_pkg::BURST_BYTES);
        end
    end

    always_comb begin
        bus_o.ar.valid = (state_r == dma_pkg::AR_CH);
        bus_o.ar.addr  = src_addr_r;
        bus_o.ar.len   = burst_len_r;
        bus_o.aw.valid = (state_r == dma_pkg::AW_CH);
        bus_o.aw.addr  = dst_addr_r;
        bus_o.aw.len   = burst_len_r;
        // read beats may already arrive while aw is pending
        bus_o.rready   = (state_r == dma_pkg::AW_CH || state_r == dma_pkg::BUSY) && !fifo_full;
        bus_o.w.valid  = (state_r == dma_pkg::BUSY) && !fifo_empty;
        bus_o.w.data   = fifo_dout;
        bus_o.w.last   = (wcnt_r == burst_len_r);
        bus_o.bready   = (state_r == dma_pkg::B_CH);
    end

    dma_fifo #(
        .DEPTH (2)
    ) u_fifo (
        .clk     (clk),
        .rst     (rst),
        .wen_i   (rhs),
        .ren_i   (whs),
        .data_i  (bus_i.r.data),
        .data_o  (fifo_dout),
        .empty_o (fifo_empty),
        .full_o  (fifo_full)
    );

endmodule

// ==== rtl/host_port.sv ====
`timescale 1ns/100ps

module host_port (
    input  logic                          clk,
    input  logic                          rst,
    input  logic                          host_req_i,
    input  logic                          host_we_i,
    input  logic [dma_pkg::ADDR_BITS-1:0] host_addr_i,
    input  logic [dma_pkg::DATA_BITS-1:0] host_wdata_i,
    output logic [dma_pkg::DATA_BITS-1:0] host_rdata_o,
    output logic                          host_done_o,
    input  dma_pkg::s2m_t                 bus_i,
    output dma_pkg::m2s_t                 bus_o
);

    dma_pkg::host_state_e state_r;

    logic                          we_r;
    logic [dma_pkg::ADDR_BITS-1:0] addr_r;
    logic [dma_pkg::DATA_BITS-1:0] wdata_r;
    logic                          rhs;
    logic                          bhs;

    assign rhs = bus_i.r.valid && bus_o.rready;
    assign bhs = bus_i.b.valid && bus_o.bready;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state_r     <= dma_pkg::H_IDLE;
            host_done_o <= 1'b0;
        end else begin
            host_done_o <= rhs || bhs;
            case (state_r)
                dma_pkg::H_IDLE: if (host_req_i) state_r <= dma_pkg::H_ADDR;
                dma_pkg::H_ADDR: begin
                    if (bus_o.aw.valid && bus_i.awready)
                        state_r <= dma_pkg::H_DATA;
                    else if (bus_o.ar.valid && bus_i.arready)
                        state_r <= dma_pkg::H_RESP;
                end
                dma_pkg::H_DATA: if (bus_i.wready) state_r <= dma_pkg::H_RESP;
                default: if (rhs || bhs) state_r <= dma_pkg::H_IDLE;
            endcase
        end
    end

    // request fields and read data
    always_ff @(posedge clk) begin
        if (state_r == dma_pkg::H_IDLE && host_req_i) begin
            we_r    <= host_we_i;
            addr_r  <= host_addr_i;
            wdata_r <= host_wdata_i;
        end
        if (rhs)
            host_rdata_o <= bus_i.r.data;
    end

    // single beats, so len is zero and every write beat is last
    always_comb begin
        bus_o.ar.valid = (state_r == dma_pkg::H_ADDR) && !we_r;
        bus_o.ar.addr  = addr_r;
        bus_o.ar.len   = '0;
        bus_o.aw.valid = (state_r == dma_pkg::H_ADDR) && we_r;
        bus_o.aw.addr  = addr_r;
        bus_o.aw.len   = '0;
        bus_o.w.valid  = (state_r == dma_pkg::H_DATA);
        bus_o.w.data   = wdata_r;
        bus_o.w.last   = 1'b1;
        bus_o.rready   = (state_r == dma_pkg::H_RESP) && !we_r;
        bus_o.bready   = (state_r == dma_pkg::H_RESP) && we_r;
    end

endmodule

// ==== rtl/bus_arbiter.sv ====
`timescale 1ns/100ps

module bus_arbiter (
    input  logic          clk,
    input  logic          rst,
    input  dma_pkg::m2s_t dma_i,
    output dma_pkg::s2m_t dma_o,
    input  dma_pkg::m2s_t host_i,
    output dma_pkg::s2m_t host_o,
    output dma_pkg::m2s_t mem_o,
    input  dma_pkg::s2m_t mem_i
);

    dma_pkg::arb_owner_e owner_r;

    // dma holds the most recent grant
    logic last_dma_r;
    logic aw_seen_r;
    logic dma_req;
    logic host_req;
    logic rd_done;
    logic release_own;

    assign dma_req  = dma_i.ar.valid || dma_i.aw.valid;
    assign host_req = host_i.ar.valid || host_i.aw.valid;

    // a read-only transaction ends on its last r beat
    assign rd_done = mem_i.r.valid && mem_o.rready && mem_i.r.last
                  && !aw_seen_r && !mem_o.aw.valid;
    assign release_own = (mem_i.b.valid && mem_o.bready) || rd_done;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            owner_r    <= dma_pkg::NONE;
            last_dma_r <= 1'b0;
            aw_seen_r  <= 1'b0;
        end else if (owner_r == dma_pkg::NONE) begin
            // tie goes to the master granted less recently
            if (dma_req && (!host_req || !last_dma_r)) begin
                owner_r    <= dma_pkg::DMA;
                last_dma_r <= 1'b1;
            end else if (host_req) begin
                owner_r    <= dma_pkg::HOST;
                last_dma_r <= 1'b0;
            end
        end else if (release_own) begin
            owner_r   <= dma_pkg::NONE;
            aw_seen_r <= 1'b0;
        end else if (mem_o.aw.valid && mem_i.awready) begin
            aw_seen_r <= 1'b1;
        end
    end

    // non-owner sees an idle bus
    always_comb begin
        mem_o  = '0;
        dma_o  = '0;
        host_o = '0;
        case (owner_r)
            dma_pkg::DMA: begin
                mem_o = dma_i;
                dma_o = mem_i;
            end
            dma_pkg::HOST: begin
                mem_o  = host_i;
                host_o = mem_i;
            end
            default: begin
                mem_o = '0;
            end
        endcase
    end

endmodule

// ==== rtl/axi_sram.sv ====
`timescale 1ns/100ps

module axi_sram (
    input  logic          clk,
    input  logic          rst,
    input  dma_pkg::m2s_t bus_i,
    output dma_pkg::s2m_t bus_o
);

    logic [dma_pkg::DATA_BITS-1:0] mem [dma_pkg::MEM_WORDS];

    // read burst engine
    logic                              arready_r;
    logic                              rd_busy_r;
    logic [dma_pkg::MEM_ADDR_BITS-1:0] rd_addr_r;
    logic [dma_pkg::LEN_BITS-1:0]      rd_cnt_r;
    logic [dma_pkg::LEN_BITS-1:0]      rd_len_r;

    // write burst engine
    logic                              awready_r;
    logic                              wr_busy_r;
    logic                              bvalid_r;
    logic [dma_pkg::MEM_ADDR_BITS-1:0] wr_addr_r;
    logic [dma_pkg::LEN_BITS-1:0]      wr_cnt_r;
    logic [dma_pkg::LEN_BITS-1:0]      wr_len_r;

    logic arhs;
    logic awhs;
    logic rhs;
    logic whs;
    logic wr_end;

    assign arhs   = bus_i.ar.valid && arready_r;
    assign awhs   = bus_i.aw.valid && awready_r;
    assign rhs    = rd_busy_r && bus_i.rready;
    assign whs    = bus_i.w.valid && wr_busy_r;
    assign wr_end = whs && (bus_i.w.last || wr_cnt_r == wr_len_r);

    always_comb begin
        bus_o.arready = arready_r;
        bus_o.awready = awready_r;
        bus_o.wready  = wr_busy_r;
        bus_o.r.valid = rd_busy_r;
        bus_o.r.data  = mem[rd_addr_r];
        bus_o.r.last  = (rd_cnt_r == rd_len_r);
        bus_o.b.valid = bvalid_r;
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            arready_r <= 1'b0;
            rd_busy_r <= 1'b0;
            rd_cnt_r  <= '0;
            awready_r <= 1'b0;
            wr_busy_r <= 1'b0;
            bvalid_r  <= 1'b0;
            wr_cnt_r  <= '0;
        end else begin
            // address accepted the cycle after valid
            arready_r <= bus_i.ar.valid && !rd_busy_r && !arready_r;
            awready_r <= bus_i.aw.valid && !wr_busy_r && !bvalid_r && !awready_r;
            if (arhs) begin
                rd_busy_r <= 1'b1;
                rd_cnt_r  <= '0;
            end else if (rhs) begin
                rd_busy_r <= !bus_o.r.last;
                rd_cnt_r  <= rd_cnt_r + 1'b1;
            end
            if (awhs) begin
                wr_busy_r <= 1'b1;
                wr_cnt_r  <= '0;
            end else if (whs) begin
                wr_busy_r <= !wr_end;
                wr_cnt_r  <= wr_cnt_r + 1'b1;
            end
            if (wr_end)
                bvalid_r <= 1'b1;
            else if (bus_i.bready)
                bvalid_r <= 1'b0;
        end
    end

    // word index drops the byte offset
    always_ff @(posedge clk) begin
        if (arhs) begin
            rd_addr_r <= bus_i.ar.addr[dma_pkg::MEM_ADDR_BITS+1:2];
            rd_len_r  <= bus_i.ar.len;
        end else if (rhs) begin
            rd_addr_r <= rd_addr_r + 1'b1;
        end
        if (awhs) begin
            wr_addr_r <= bus_i.aw.addr[dma_pkg::MEM_ADDR_BITS+1:2];
            wr_len_r  <= bus_i.aw.len;
        end else if (whs) begin
            mem[wr_addr_r] <= bus_i.w.data;
            wr_addr_r      <= wr_addr_r + 1'b1;
        end
    end

endmodule

// ==== rtl/dma_subsystem.sv ====
`timescale 1ns/100ps

module dma_subsystem (
    input  logic                          clk,
    input  logic                          rst,
    input  logic                          dma_start_i,
    input  logic [dma_pkg::ADDR_BITS-1:0] src_addr_i,
    input  logic [dma_pkg::ADDR_BITS-1:0] dst_addr_i,
    input  logic [dma_pkg::DATA_BITS-1:0] qty_i,
    output logic                          dma_fin_o,
    input  logic                          host_req_i,
    input  logic                          host_we_i,
    input  logic [dma_pkg::ADDR_BITS-1:0] host_addr_i,
    input  logic [dma_pkg::DATA_BITS-1:0] host_wdata_i,
    output logic [dma_pkg::DATA_BITS-1:0] host_rdata_o,
    output logic                          host_done_o
);

    dma_pkg::m2s_t dma_m2s;
    dma_pkg::s2m_t dma_s2m;
    dma_pkg::m2s_t host_m2s;
    dma_pkg::s2m_t host_s2m;
    dma_pkg::m2s_t mem_m2s;
    dma_pkg::s2m_t mem_s2m;

    dma_master u_dma (
        .clk         (clk),
        .rst         (rst),
        .dma_start_i (dma_start_i),
        .src_addr_i  (src_addr_i),
        .dst_addr_i  (dst_addr_i),
        .qty_i       (qty_i),
        .bus_i       (dma_s2m),
        .bus_o       (dma_m2s),
        .dma_fin_o   (dma_fin_o)
    );

    host_port u_host (
        .clk          (clk),
        .rst          (rst),
        .host_req_i   (host_req_i),
        .host_we_i    (host_we_i),
        .host_addr_i  (host_addr_i),
        .host_wdata_i (host_wdata_i),
        .host_rdata_o (host_rdata_o),
        .host_done_o  (host_done_o),
        .bus_i        (host_s2m),
        .bus_o        (host_m2s)
    );

    bus_arbiter u_arb (
        .clk    (clk),
        .rst    (rst),
        .dma_i  (dma_m2s),
        .dma_o  (dma_s2m),
        .host_i (host_m2s),
        .host_o (host_s2m),
        .mem_o  (mem_m2s),
        .mem_i  (mem_s2m)
    );

    axi_sram u_sram (
        .clk   (clk),
        .rst   (rst),
        .bus_i (mem_m2s),
        .bus_o (mem_s2m)
    );

endmodule

// ==== testbench/dma_checker.sv ====
`timescale 1ns/100ps

module dma_checker (
    input logic          clk,
    input logic          rst,
    input dma_pkg::m2s_t m2s_i,
    input dma_pkg::s2m_t s2m_i,
    input logic          fin_i
);

    // assertion failures so far
    int fail_count = 0;

    logic [1:0] fill_r;
    logic       push;
    logic       pop;

    assign push = s2m_i.r.valid && m2s_i.rready;
    assign pop  = m2s_i.w.valid && s2m_i.wready;

    // fifo fill level rebuilt from the bus handshakes
    always_ff @(posedge clk or posedge rst) begin
        if (rst)
            fill_r <= '0;
        else if (push && !pop)
            fill_r <= fill_r + 1'b1;
        else if (pop && !push)
            fill_r <= fill_r - 1'b1;
    end

    // address requests stay put until accepted
    ar_hold: assert property (@(posedge clk) disable iff (rst)
        m2s_i.ar.valid && !s2m_i.arready |=> m2s_i.ar.valid && $stable(m2s_i.ar))
        else begin
            fail_count++;
            $error("ar request dropped or changed before arready");
        end

    aw_hold: assert property (@(posedge clk) disable iff (rst)
        m2s_i.aw.valid && !s2m_i.awready |=> m2s_i.aw.valid && $stable(m2s_i.aw))
        else begin
            fail_count++;
            $error("aw request dropped or changed before awready");
        end

    // finish is a single-cycle pulse
    fin_pulse: assert property (@(posedge clk) disable iff (rst)
        fin_i |=> !fin_i)
        else begin
            fail_count++;
            $error("dma finish strobe high for two cycles in a row");
        end

    // write data only comes out of a filled fifo
    w_from_fifo: assert property (@(posedge clk) disable iff (rst)
        m2s_i.w.valid |-> fill_r != '0)
        else begin
            fail_count++;
            $error("wvalid raised while the fifo is empty");
        end

endmodule

// ==== testbench/tb_dma_subsystem.sv ====
`timescale 1ns/100ps

module tb_dma_subsystem;

    typedef struct {
        string                         name;
        logic [dma_pkg::ADDR_BITS-1:0] src;
        logic [dma_pkg::ADDR_BITS-1:0] dst;
        logic [dma_pkg::DATA_BITS-1:0] qty;
        logic                          overlap;
    } copy_case_t;

    logic                          clk = 1'b0;
    logic                          rst;
    logic                          dma_start_i;
    logic [dma_pkg::ADDR_BITS-1:0] src_addr_i;
    logic [dma_pkg::ADDR_BITS-1:0] dst_addr_i;
    logic [dma_pkg::DATA_BITS-1:0] qty_i;
    logic                          dma_fin_o;
    logic                          host_req_i;
    logic                          host_we_i;
    logic [dma_pkg::ADDR_BITS-1:0] host_addr_i;
    logic [dma_pkg::DATA_BITS-1:0] host_wdata_i;
    logic [dma_pkg::DATA_BITS-1:0] host_rdata_o;
    logic                          host_done_o;

    // mirror of what the sram should hold
    logic [dma_pkg::DATA_BITS-1:0] model [dma_pkg::MEM_WORDS];
    logic [dma_pkg::DATA_BITS-1:0] lcg_state;
    logic [dma_pkg::ADDR_BITS-1:0] side_addr = 32'h0000_0F00;
    copy_case_t                    cases [5];
    int                            data_errors = 0;
    int                            count_errors = 0;
    int                            checks = 0;
    int                            cycle_count = 0;
    int                            cycle_limit = 0;
    int                            fin_count;

    dma_subsystem uut (
        .clk          (clk),
        .rst          (rst),
        .dma_start_i  (dma_start_i),
        .src_addr_i   (src_addr_i),
        .dst_addr_i   (dst_addr_i),
        .qty_i        (qty_i),
        .dma_fin_o    (dma_fin_o),
        .host_req_i   (host_req_i),
        .host_we_i    (host_we_i),
        .host_addr_i  (host_addr_i),
        .host_wdata_i (host_wdata_i),
        .host_rdata_o (host_rdata_o),
        .host_done_o  (host_done_o)
    );

    bind dma_master dma_checker u_checker (
        .clk   (clk),
        .rst   (rst),
        .m2s_i (bus_o),
        .s2m_i (bus_i),
        .fin_i (dma_fin_o)
    );

    always #4 clk = ~clk;

    always @(posedge clk or posedge rst) begin
        if (rst)
            fin_count <= 0;
        else if (dma_fin_o)
            fin_count <= fin_count + 1;
    end

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= cycle_limit) begin
            $display("ERROR: simulation did not finish within %0d cycles", cycle_limit);
            $display("Test failures found");
            $finish;
        end
    end

    function automatic logic [dma_pkg::DATA_BITS-1:0] random_word();
        lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
        return lcg_state;
    endfunction

    function automatic logic [dma_pkg::MEM_ADDR_BITS-1:0] word_index(
        input logic [dma_pkg::ADDR_BITS-1:0] addr
    );
        return addr[dma_pkg::MEM_ADDR_BITS+1:2];
    endfunction

    task automatic write_word(input logic [dma_pkg::ADDR_BITS-1:0] addr,
                              input logic [dma_pkg::DATA_BITS-1:0] data);
        @(posedge clk);
        host_req_i   <= 1'b1;
        host_we_i    <= 1'b1;
        host_addr_i  <= addr;
        host_wdata_i <= data;
        @(posedge clk);
        host_req_i <= 1'b0;
        @(posedge clk);
        while (!host_done_o) @(posedge clk);
        model[word_index(addr)] = data;
    endtask

    task automatic read_word(input logic [dma_pkg::ADDR_BITS-1:0] addr,
                             output logic [dma_pkg::DATA_BITS-1:0] data);
        @(posedge clk);
        host_req_i  <= 1'b1;
        host_we_i   <= 1'b0;
        host_addr_i <= addr;
        @(posedge clk);
        host_req_i <= 1'b0;
        @(posedge clk);
        while (!host_done_o) @(posedge clk);
        data = host_rdata_o;
    endtask

    task automatic start_copy(input copy_case_t tc);
        @(posedge clk);
        dma_start_i <= 1'b1;
        src_addr_i  <= tc.src;
        dst_addr_i  <= tc.dst;
        qty_i       <= tc.qty;
        @(posedge clk);
        dma_start_i <= 1'b0;
    endtask

    task automatic check_data(input string name, input logic [dma_pkg::DATA_BITS-1:0] exp,
                              input logic [dma_pkg::DATA_BITS-1:0] act);
        checks++;
        if (act !== exp) begin
            data_errors++;
            $display("FAIL %s: expected %08h, actual %08h", name, exp, act);
        end
    endtask

    task automatic check_count(input string name, input int exp, input int act);
        checks++;
        if (act != exp) begin
            count_errors++;
            $display("FAIL %s: expected %0d, actual %0d", name, exp, act);
        end
    endtask

    initial begin
        logic [dma_pkg::DATA_BITS-1:0] rdata;
        logic [dma_pkg::ADDR_BITS-1:0] after_addr;
        int                            fin_before;

        lcg_state    = 32'd5676;
        rst          = 1'b1;
        dma_start_i  = 1'b0;
        src_addr_i   = '0;
        dst_addr_i   = '0;
        qty_i        = '0;
        host_req_i   = 1'b0;
        host_we_i    = 1'b0;
        host_addr_i  = '0;
        host_wdata_i = '0;

        // name, src, dst, qty, host read during the copy
        cases[0] = '{"single_burst", 32'h0000_0000, 32'h0000_0400, 32'd12, 1'b0};
        cases[1] = '{"multi_burst", 32'h0000_0100, 32'h0000_0600, 32'd37, 1'b0};
        cases[2] = '{"zero_qty", 32'h0000_0200, 32'h0000_0800, 32'd0, 1'b0};
        cases[3] = '{"overlap_read", 32'h0000_0300, 32'h0000_0A00, 32'd20, 1'b1};
        cases[4] = '{"full_burst", 32'h0000_0040, 32'h0000_0C00, 32'd16, 1'b0};

        cycle_limit = 200;
        foreach (cases[c])
            cycle_limit += 8 * 3 * int'(cases[c].qty);

        repeat (2) @(posedge clk);
        rst <= 1'b0;

        // plain host access first
        write_word(32'h0000_0FF0, random_word());
        read_word(32'h0000_0FF0, rdata);
        check_data("host_rw", model[word_index(32'h0000_0FF0)], rdata);

        foreach (cases[c]) begin
            for (int i = 0; i < int'(cases[c].qty); i++)
                write_word(cases[c].src + 32'(4 * i), random_word());
            // guard word just past the destination block
            after_addr = cases[c].dst + (cases[c].qty << 2);
            write_word(after_addr, random_word());
            if (cases[c].overlap)
                write_word(side_addr, random_word());

            fin_before = fin_count;
            start_copy(cases[c]);
            if (cases[c].overlap) begin
                read_word(side_addr, rdata);
                check_data({cases[c].name, "_side"}, model[word_index(side_addr)], rdata);
            end
            while (fin_count == fin_before) @(posedge clk);

            for (int i = 0; i < int'(cases[c].qty); i++)
                model[word_index(cases[c].dst + 32'(4 * i))] =
                    model[word_index(cases[c].src + 32'(4 * i))];

            for (int i = 0; i < int'(cases[c].qty); i++) begin
                read_word(cases[c].dst + 32'(4 * i), rdata);
                check_data($sformatf("%s[%0d]", cases[c].name, i),
                           model[word_index(cases[c].dst + 32'(4 * i))], rdata);
            end
            read_word(after_addr, rdata);
            check_data({cases[c].name, "_after"}, model[word_index(after_addr)], rdata);
            check_count({cases[c].name, "_fin"}, 1, fin_count - fin_before);
        end

        $display("Summary: %0d checks, %0d data errors, %0d count errors, %0d assertion errors",
                 checks, data_errors, count_errors, uut.u_dma.u_checker.fail_count);
        if (data_errors == 0 && count_errors == 0 && uut.u_dma.u_checker.fail_count == 0)
            $display("All tests passed!");
        else
            $display("Test failures found");
        $finish;
    end

endmodule

// ==== build.f ====
rtl/dma_pkg.sv
rtl/dma_fifo.sv
rtl/dma_master.sv
rtl/host_port.sv
rtl/bus_arbiter.sv
rtl/axi_sram.sv
rtl/dma_subsystem.sv
testbench/dma_checker.sv
testbench/tb_dma_subsystem.sv

// ==== Makefile ====
VERILATOR = verilator
FLAGS     = --binary --timing --assert -j 0
TOP       = tb_dma_subsystem
FILELIST  = build.f
OBJ_DIR   = obj_dir
PASS_MSG  = All tests passed!

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: compile
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qF "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
